//--- verilog.f
+incdir+.
video_pkg.sv
video_timing.sv
video_mmr.sv
video_colmix.sv
video_pal.sv
video_top.sv
tb_video.sv

//--- Bender.yml
package:
  name: video_backend

export_include_dirs:
  - .

sources:
  - files:
      - video_pkg.sv
      - video_timing.sv
      - video_mmr.sv
      - video_colmix.sv
      - video_pal.sv
      - video_top.sv
  - target: simulation
    files:
      - tb_video.sv

//--- tb_video.sv
// Self-checking testbench for the video back end. Runs two frames with
// random palette data, layer pixels and layer orders against reference models.
`timescale 1ns/1ns
`include "video_defines.svh"

module tb_video import video_pkg::*; ();

    localparam int CEN_DIV      = 4;
    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL * CEN_DIV;
    // Two frames plus reset, palette fill and some slack
    localparam int TIMEOUT_CYCLES = 2 * FRAME_CYCLES + FRAME_CYCLES / 4;
    localparam int LAST           = `PIXEL_LATENCY - 1;
    localparam logic [4:0]  ADDR_CTRL     = `REG_LAYER_CTRL;
    localparam logic [4:0]  ADDR_RASTER   = `REG_RASTER_LINE;
    localparam logic [4:0]  ADDR_UNUSED   = 5'd9;
    localparam logic [15:0] RASTER_TARGET = 16'd100;

    typedef struct packed {
        logic valid;
        rgb_t rgb;
        logic hb;
        logic vb;
    } pipe_t;

    logic        clk;
    logic        rst;
    logic        pxl_cen;
    cpu_req_t    cpu_req;
    pal_wr_t     pal_wr;
    layer_pxl_t  obj_pxl;
    layer_pxl_t  scr1_pxl;
    layer_pxl_t  scr2_pxl;
    layer_pxl_t  scr3_pxl;
    beam_t       beam;
    sync_t       sync;
    logic [15:0] mmr_dout;
    logic        raster;
    rgb_t        rgb;
    logic        lhbl_dly;
    logic        lvbl_dly;

    // Reference state
    integer      seed;
    pal_colour_t pal_model [0:2047];
    logic [15:0] ctrl_shadow;
    logic [15:0] raster_shadow;
    beam_t       exp_beam;
    sync_t       exp_sync;
    pipe_t       pipe [`PIXEL_LATENCY];
    logic        check_en = 1'b0;
    logic        cen_done = 1'b0;
    logic        frame_wrap = 1'b0;
    logic        raster_armed = 1'b0;
    int          cen_phase = 0;
    int          raster_count = 0;
    int          frames_done = 0;
    int          errors = 0;
    int          cycles = 0;

    video_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic sync_t sync_ref(beam_t b);
        sync_t s;
        s.hb = !(b.hdump >= `H_VIS_START && b.hdump < `H_VIS_END);
        s.vb = !(b.vdump >= `V_VIS_START && b.vdump < `V_VIS_END);
        s.hs = b.hdump >= `HS_START && b.hdump < `HS_END;
        s.vs = b.vdump >= `VS_START && b.vdump < `VS_END;
        return s;
    endfunction

    // Walk slots bottom to top so the highest visible one is kept
    function automatic pal_addr_t mix_ref(logic [15:0] ctrl, layer_pxl_t obj,
                                          layer_pxl_t s1, layer_pxl_t s2, layer_pxl_t s3);
        layer_pxl_t pix [4];
        pal_addr_t  res;
        logic [1:0] code;
        pix[0] = obj;
        pix[1] = s1;
        pix[2] = s2;
        pix[3] = s3;
        res = '1;
        for (int slot = 0; slot < 4; slot++) begin
            code = ctrl[`LAYER_ORDER_LSB + 2 * slot +: 2];
            if (ctrl[`LAYER_EN_LSB + code] && pix[code].colour != `TRANSPARENT_COLOUR) begin
                res.layer  = layer_e'(code);
                res.group  = pix[code].group;
                res.colour = pix[code].colour;
            end
        end
        return res;
    endfunction

    function automatic rgb_t scale_ref(pal_colour_t c);
        int   gain;
        rgb_t res;
        gain = 16 + c.bright;
        res.red   = 8'((c.red * gain) / 2);
        res.green = 8'((c.green * gain) / 2);
        res.blue  = 8'((c.blue * gain) / 2);
        return res;
    endfunction

    function automatic layer_pxl_t random_pixel();
        layer_pxl_t p;
        p = 9'($random(seed));
        // Roughly one pixel in four is see-through
        if (($random(seed) & 3) == 0) begin
            p.colour = 4'(`TRANSPARENT_COLOUR);
        end
        return p;
    endfunction

    task automatic finish_with_errors();
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(string msg);
        errors++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        finish_with_errors();
    endtask

    task automatic check_sync(sync_t got, sync_t exp, string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: got %04b, expected %04b", what, got, exp));
        end
    endtask

    task automatic check_rgb(rgb_t got, rgb_t exp, string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: got %06h, expected %06h", what, got, exp));
        end
    endtask

    task automatic check_reg(logic [15:0] got, logic [15:0] exp, string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: got %04h, expected %04h", what, got, exp));
        end
    endtask

    task automatic check_beam(beam_t got, beam_t exp, string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: got h=%0d v=%0d, expected h=%0d v=%0d",
                                      what, got.hdump, got.vdump, exp.hdump, exp.vdump));
        end
    endtask

    task automatic cpu_write(logic [4:0] addr, logic [1:0] dsn, logic [15:0] data);
        logic [15:0] mask;
        mask = {{8{!dsn[1]}}, {8{!dsn[0]}}};
        @(negedge clk);
        cpu_req = '{cs: 1'b1, rnw: 1'b0, addr: addr, dsn: dsn, data: data};
        @(negedge clk);
        cpu_req = '0;
        if (addr == ADDR_CTRL) begin
            ctrl_shadow = (ctrl_shadow & ~mask) | (data & mask);
        end else if (addr == ADDR_RASTER) begin
            raster_shadow = (raster_shadow & ~mask) | (data & mask);
        end
    endtask

    task automatic read_check(logic [4:0] addr, logic [15:0] exp, string what);
        @(negedge clk);
        cpu_req = '{cs: 1'b1, rnw: 1'b1, addr: addr, dsn: 2'b00, data: 16'd0};
        @(negedge clk);
        cpu_req = '0;
        check_reg(mmr_dout, exp, what);
    endtask

    task automatic fill_palette();
        pal_colour_t c;
        for (int a = 0; a < 2048; a++) begin
            @(negedge clk);
            c = 16'($random(seed));
            pal_wr = '{we: 1'b1, addr: 11'(a), data: c};
            pal_model[a] = c;
        end
        @(negedge clk);
        pal_wr = '0;
    endtask

    // One pxl_cen step of the beam and of the pixel pipeline
    task automatic advance_model();
        pipe_t entry;
        int    h;
        int    v;
        entry.valid = check_en;
        entry.hb    = exp_sync.hb;
        entry.vb    = exp_sync.vb;
        if (exp_sync.hb || exp_sync.vb) begin
            entry.rgb = '0;
        end else begin
            entry.rgb = scale_ref(pal_model[mix_ref(ctrl_shadow, obj_pxl, scr1_pxl,
                                                    scr2_pxl, scr3_pxl)]);
        end
        for (int i = LAST; i > 0; i--) begin
            pipe[i] = pipe[i - 1];
        end
        pipe[0] = entry;
        h = (exp_beam.hdump + 1) % `H_TOTAL;
        v = exp_beam.vdump;
        if (h == 0) begin
            v = (v + 1) % `V_TOTAL;
        end
        exp_beam.hdump = 9'(h);
        exp_beam.vdump = 9'(v);
        exp_sync   = sync_ref(exp_beam);
        frame_wrap = (h == 0 && v == 0);
        cen_done   = 1'b1;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            finish_with_errors();
        end
    end

    // Pixel clock enable and layer pixels
    always @(negedge clk) begin
        cen_phase = (cen_phase + 1) % CEN_DIV;
        pxl_cen   = (cen_phase == 0);
        if (pxl_cen) begin
            obj_pxl  = random_pixel();
            scr1_pxl = random_pixel();
            scr2_pxl = random_pixel();
            scr3_pxl = random_pixel();
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            exp_beam = '0;
            exp_sync = sync_ref('0);
            for (int i = 0; i <= LAST; i++) begin
                pipe[i] = '{valid: 1'b0, rgb: '0, hb: 1'b1, vb: 1'b1};
            end
        end else if (pxl_cen) begin
            advance_model();
        end
    end

    // Compare on the falling edge after each pixel step
    always @(negedge clk) begin
        if (raster) begin
            raster_count++;
            check_beam(beam, beam_t'{hdump: 9'd0, vdump: raster_shadow[8:0]},
                       "beam at raster pulse");
        end
        if (cen_done) begin
            cen_done = 1'b0;
            check_beam(beam, exp_beam, "beam position");
            check_sync(sync, exp_sync, "sync decode");
            check_sync(sync_t'{hs: 1'b0, vs: 1'b0, hb: !lhbl_dly, vb: !lvbl_dly},
                       sync_t'{hs: 1'b0, vs: 1'b0, hb: pipe[LAST].hb, vb: pipe[LAST].vb},
                       "delayed blanking");
            if (pipe[LAST].valid) begin
                check_rgb(rgb, pipe[LAST].rgb, "pixel colour");
            end
            if (frame_wrap) begin
                frame_wrap = 1'b0;
                if (raster_armed && raster_count != 1) begin
                    report_mismatch($sformatf("%0d raster pulses in frame %0d, expected 1",
                                              raster_count, frames_done));
                end
                raster_count = 0;
                frames_done++;
            end
        end
    end

    initial begin
        logic [15:0] ctrl_val;
        int          gap;
        int          changes;
        seed          = 32'hc97;
        rst           = 1'b1;
        pxl_cen       = 1'b0;
        cpu_req       = '0;
        pal_wr        = '0;
        obj_pxl       = '0;
        scr1_pxl      = '0;
        scr2_pxl      = '0;
        scr3_pxl      = '0;
        ctrl_shadow   = '0;
        raster_shadow = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        fill_palette();
        check_en = 1'b1;

        // Byte lanes on both registers
        cpu_write(ADDR_CTRL, 2'b00, 16'ha5c3);
        read_check(ADDR_CTRL, ctrl_shadow, "layer_ctrl word write");
        cpu_write(ADDR_CTRL, 2'b10, 16'h1234);
        read_check(ADDR_CTRL, ctrl_shadow, "layer_ctrl low byte write");
        cpu_write(ADDR_CTRL, 2'b01, 16'h5678);
        read_check(ADDR_CTRL, ctrl_shadow, "layer_ctrl high byte write");
        cpu_write(ADDR_RASTER, 2'b00, 16'hbeef);
        check_reg(mmr_dout, ctrl_shadow, "read data held over a write");
        read_check(ADDR_RASTER, raster_shadow, "raster_line word write");
        cpu_write(ADDR_RASTER, 2'b10, 16'h1200);
        read_check(ADDR_RASTER, raster_shadow, "raster_line low byte write");
        cpu_write(ADDR_RASTER, 2'b11, 16'hffff);
        read_check(ADDR_RASTER, raster_shadow, "raster_line no lane write");
        read_check(ADDR_UNUSED, 16'd0, "unused address");

        cpu_write(ADDR_RASTER, 2'b00, RASTER_TARGET);
        raster_armed = 1'b1;

        // New random layer order every 8 to 16 lines
        changes = 0;
        while (frames_done < 2) begin
            ctrl_val = 16'($random(seed));
            if (changes % 4 == 3) begin
                ctrl_val[`LAYER_EN_LSB +: 4] = 4'd0;
            end
            cpu_write(ADDR_CTRL, 2'b00, ctrl_val);
            read_check(ADDR_CTRL, ctrl_shadow, "layer_ctrl random write");
            changes++;
            gap = 16384 + ($random(seed) & 16'h3fff);
            for (int i = 0; i < gap && frames_done < 2; i++) begin
                @(negedge clk);
            end
        end

        if (errors == 0) begin
            $display("No errors");
            $finish;
        end else begin
            finish_with_errors();
        end
    end

endmodule

//--- video_top.sv
// Top level of the video back end. Connects the beam timing, the CPU
// registers, the layer mixer and the palette stage.
`timescale 1ns/1ns

module video_top import video_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        pxl_cen,
    input  cpu_req_t    cpu_req,
    input  pal_wr_t     pal_wr,
    input  layer_pxl_t  obj_pxl,
    input  layer_pxl_t  scr1_pxl,
    input  layer_pxl_t  scr2_pxl,
    input  layer_pxl_t  scr3_pxl,
    output beam_t       beam,
    output sync_t       sync,
    output logic [15:0] mmr_dout,
    output logic        raster,
    output rgb_t        rgb,
    output logic        lhbl_dly,
    output logic        lvbl_dly
);

    logic        line_start;
    logic [15:0] layer_ctrl;
    pal_addr_t   pal_addr;

    video_timing timing_i (
        .clk        (clk),
        .rst        (rst),
        .pxl_cen    (pxl_cen),
        .beam       (beam),
        .sync       (sync),
        .line_start (line_start)
    );

    video_mmr mmr_i (
        .clk        (clk),
        .rst        (rst),
        .cpu_req    (cpu_req),
        .line_start (line_start),
        .vdump      (beam.vdump),
        .mmr_dout   (mmr_dout),
        .layer_ctrl (layer_ctrl),
        .raster     (raster)
    );

    // Layer pixels belong to the current beam position
    video_colmix colmix_i (
        .clk        (clk),
        .rst        (rst),
        .pxl_cen    (pxl_cen),
        .layer_ctrl (layer_ctrl),
        .obj_pxl    (obj_pxl),
        .scr1_pxl   (scr1_pxl),
        .scr2_pxl   (scr2_pxl),
        .scr3_pxl   (scr3_pxl),
        .pal_addr   (pal_addr)
    );

    video_pal pal_i (
        .clk        (clk),
        .rst        (rst),
        .pxl_cen    (pxl_cen),
        .pal_wr     (pal_wr),
        .pal_addr   (pal_addr),
        .sync       (sync),
        .rgb        (rgb),
        .lhbl_dly   (lhbl_dly),
        .lvbl_dly   (lvbl_dly)
    );

endmodule

//--- video_pal.sv
// Palette stage. Looks up the mixed pixel in the palette RAM, applies
// the brightness nibble per channel and blanks to black in the borders.
`timescale 1ns/1ns
`include "video_defines.svh"

module video_pal import video_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      pxl_cen,
    input  pal_wr_t   pal_wr,
    input  pal_addr_t pal_addr,
    input  sync_t     sync,
    output rgb_t      rgb,
    output logic      lhbl_dly,
    output logic      lvbl_dly
);

    pal_colour_t pal_ram [0:2047];
    pal_colour_t rd_colour;

    // Blanking history, bit 0 is the newest
    logic [`PIXEL_LATENCY-1:0] hb_sr;
    logic [`PIXEL_LATENCY-1:0] vb_sr;
    logic                      blank_now;

    // Output level is nibble * (16 + bright) / 2, at most 232
    function automatic logic [7:0] scale(logic [3:0] level, logic [3:0] bright);
        logic [8:0] prod;
        prod = 9'(level) * 9'(5'd16 + 5'(bright));
        return prod[8:1];
    endfunction

    always_ff @(posedge clk) begin
        if (pal_wr.we) begin
            pal_ram[pal_wr.addr] <= pal_wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            rd_colour <= pal_ram[pal_addr];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hb_sr <= '1;
            vb_sr <= '1;
        end else if (pxl_cen) begin
            hb_sr <= {hb_sr[`PIXEL_LATENCY-2:0], sync.hb};
            vb_sr <= {vb_sr[`PIXEL_LATENCY-2:0], sync.vb};
        end
    end

    // Blanking of the pixel that is entering the scaling register
    assign blank_now = hb_sr[`PIXEL_LATENCY-2] | vb_sr[`PIXEL_LATENCY-2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rgb <= '0;
        end else if (pxl_cen) begin
            if (blank_now) begin
                rgb <= '0;
            end else begin
                rgb.red   <= scale(rd_colour.red, rd_colour.bright);
                rgb.green <= scale(rd_colour.green, rd_colour.bright);
                rgb.blue  <= scale(rd_colour.blue, rd_colour.bright);
            end
        end
    end

    assign lhbl_dly = ~hb_sr[`PIXEL_LATENCY-1];
    assign lvbl_dly = ~vb_sr[`PIXEL_LATENCY-1];

endmodule

//--- video_colmix.sv
// Layer priority mixer. Picks the topmost enabled, non-transparent
// layer pixel and turns it into a palette address, one pixel per pxl_cen.
`timescale 1ns/1ns
`include "video_defines.svh"

module video_colmix import video_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        pxl_cen,
    input  logic [15:0] layer_ctrl,
    input  layer_pxl_t  obj_pxl,
    input  layer_pxl_t  scr1_pxl,
    input  layer_pxl_t  scr2_pxl,
    input  layer_pxl_t  scr3_pxl,
    output pal_addr_t   pal_addr
);

    localparam pal_addr_t BACKDROP = pal_addr_t'('1);

    logic [3:0] layer_en;
    layer_pxl_t pxl_by_layer [4];
    pal_addr_t  mix_addr;
    layer_e     slot_layer;
    layer_pxl_t slot_pxl;
    logic       found;

    assign layer_en = layer_ctrl[`LAYER_EN_LSB +: 4];

    // Indexed by layer code
    assign pxl_by_layer[LAYER_OBJ]  = obj_pxl;
    assign pxl_by_layer[LAYER_SCR1] = scr1_pxl;
    assign pxl_by_layer[LAYER_SCR2] = scr2_pxl;
    assign pxl_by_layer[LAYER_SCR3] = scr3_pxl;

    // Scan slots from the top one down, the first visible pixel wins
    always_comb begin
        mix_addr   = BACKDROP;
        found      = 1'b0;
        slot_layer = LAYER_OBJ;
        slot_pxl   = '0;
        for (int i = 3; i >= 0; i--) begin
            slot_layer = layer_e'(layer_ctrl[`LAYER_ORDER_LSB + 2*i +: 2]);
            slot_pxl   = pxl_by_layer[slot_layer];
            if (!found && layer_en[slot_layer] &&
                slot_pxl.colour != 4'(`TRANSPARENT_COLOUR)) begin
                found           = 1'b1;
                mix_addr.layer  = slot_layer;
                mix_addr.group  = slot_pxl.group;
                mix_addr.colour = slot_pxl.colour;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pal_addr <= BACKDROP;
        end else if (pxl_cen) begin
            pal_addr <= mix_addr;
        end
    end

endmodule

//--- video_mmr.sv
// CPU register block: layer control and raster line registers with
// byte-lane writes, registered readback and the raster line interrupt.
`timescale 1ns/1ns

module video_mmr import video_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  cpu_req_t    cpu_req,
    input  logic        line_start,
    input  logic [8:0]  vdump,
    output logic [15:0] mmr_dout,
    output logic [15:0] layer_ctrl,
    output logic        raster
);

    logic [15:0] raster_line;
    logic        wr_en;
    logic        rd_en;
    mmr_reg_e    reg_sel;
    logic [15:0] rd_data;

    // dsn[1] guards the upper byte, dsn[0] the lower one
    function automatic logic [15:0] merge_bytes(
        logic [15:0] cur,
        logic [15:0] din,
        logic [1:0]  dsn
    );
        logic [15:0] res;
        res = cur;
        if (!dsn[1]) begin
            res[15:8] = din[15:8];
        end
        if (!dsn[0]) begin
            res[7:0] = din[7:0];
        end
        return res;
    endfunction

    assign wr_en   = cpu_req.cs && !cpu_req.rnw;
    assign rd_en   = cpu_req.cs && cpu_req.rnw;
    assign reg_sel = mmr_reg_e'(cpu_req.addr);

    always_comb begin
        case (reg_sel)
            MMR_LAYER_CTRL:  rd_data = layer_ctrl;
            MMR_RASTER_LINE: rd_data = raster_line;
            default:         rd_data = 16'd0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            layer_ctrl  <= 16'd0;
            raster_line <= 16'd0;
        end else if (wr_en) begin
            case (reg_sel)
                MMR_LAYER_CTRL:
                    layer_ctrl <= merge_bytes(layer_ctrl, cpu_req.data, cpu_req.dsn);
                MMR_RASTER_LINE:
                    raster_line <= merge_bytes(raster_line, cpu_req.data, cpu_req.dsn);
                default: ;
            endcase
        end
    end

    // Read data holds until the next read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mmr_dout <= 16'd0;
        end else if (rd_en) begin
            mmr_dout <= rd_data;
        end
    end

    // vdump already shows the new line while line_start is high
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            raster <= 1'b0;
        end else begin
            raster <= line_start && (vdump == raster_line[8:0]);
        end
    end

endmodule

//--- video_timing.sv
// Beam timing generator. Steps the horizontal and vertical counters
// once per pixel clock enable and registers blanking and sync with them.
`timescale 1ns/1ns
`include "video_defines.svh"

module video_timing import video_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  pxl_cen,
    output beam_t beam,
    output sync_t sync,
    output logic  line_start
);

    localparam logic [8:0] H_LAST = 9'(`H_TOTAL - 1);
    localparam logic [8:0] V_LAST = 9'(`V_TOTAL - 1);

    beam_t beam_nxt;

    // Blanking outside the visible window, sync inside its range
    function automatic sync_t decode_sync(beam_t b);
        sync_t s;
        s.hb = (b.hdump < `H_VIS_START) || (b.hdump >= `H_VIS_END);
        s.vb = (b.vdump < `V_VIS_START) || (b.vdump >= `V_VIS_END);
        s.hs = (b.hdump >= `HS_START) && (b.hdump < `HS_END);
        s.vs = (b.vdump >= `VS_START) && (b.vdump < `VS_END);
        return s;
    endfunction

    always_comb begin
        beam_nxt = beam;
        if (beam.hdump == H_LAST) begin
            beam_nxt.hdump = 9'd0;
            if (beam.vdump == V_LAST) begin
                beam_nxt.vdump = 9'd0;
            end else begin
                beam_nxt.vdump = beam.vdump + 9'd1;
            end
        end else begin
            beam_nxt.hdump = beam.hdump + 9'd1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            beam       <= '0;
            sync       <= decode_sync('0);
            line_start <= 1'b0;
        end else begin
            // High for the clk right after hdump wrapped to 0
            line_start <= pxl_cen && (beam.hdump == H_LAST);
            if (pxl_cen) begin
                beam <= beam_nxt;
                sync <= decode_sync(beam_nxt);
            end
        end
    end

endmodule

//--- video_pkg.sv
// Types shared by the video back end: layer codes, register map,
// pixel and colour words, beam position, sync and bus requests.
`include "video_defines.svh"

package video_pkg;

    typedef enum logic [1:0] {
        LAYER_OBJ  = 2'd0,
        LAYER_SCR1 = 2'd1,
        LAYER_SCR2 = 2'd2,
        LAYER_SCR3 = 2'd3
    } layer_e;

    typedef enum logic [4:0] {
        MMR_LAYER_CTRL  = 5'(`REG_LAYER_CTRL),
        MMR_RASTER_LINE = 5'(`REG_RASTER_LINE)
    } mmr_reg_e;

    typedef struct packed {
        logic [4:0] group;
        logic [3:0] colour;
    } layer_pxl_t;

    typedef struct packed {
        layer_e     layer;
        logic [4:0] group;
        logic [3:0] colour;
    } pal_addr_t;

    // Palette entry, brightness in the top nibble
    typedef struct packed {
        logic [3:0] bright;
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } pal_colour_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    typedef struct packed {
        logic [8:0] hdump;
        logic [8:0] vdump;
    } beam_t;

    typedef struct packed {
        logic hs;
        logic vs;
        logic hb;
        logic vb;
    } sync_t;

    typedef struct packed {
        logic        cs;
        logic        rnw;
        logic [4:0]  addr;
        logic [1:0]  dsn;
        logic [15:0] data;
    } cpu_req_t;

    typedef struct packed {
        logic        we;
        logic [10:0] addr;
        pal_colour_t data;
    } pal_wr_t;

endpackage

//--- video_defines.svh
// Shared constants for the arcade video back end.
// Included by the package and by every module that needs geometry,
// register layout or pipeline depth.
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// Horizontal geometry in pixels
`define H_TOTAL         512
`define H_VIS_START     64
`define H_VIS_END       448
`define HS_START        468
`define HS_END          500

// Vertical geometry in lines
`define V_TOTAL         262
`define V_VIS_START     16
`define V_VIS_END       240
`define VS_START        244
`define VS_END          248

// Register word offsets
`define REG_LAYER_CTRL  0
`define REG_RASTER_LINE 1

// layer_ctrl fields: enables are obj, scr1, scr2, scr3; order runs bottom to top
`define LAYER_EN_LSB    1
`define LAYER_ORDER_LSB 6

`define TRANSPARENT_COLOUR 15
`define PIXEL_LATENCY   3

`endif
